// File: logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // **************************************************
    // Sizes
    // **************************************************

    localparam int XLEN        = 32;
    localparam int QUEUE_DEPTH = 16;
    localparam int IMEM_WORDS  = 64;

    // **************************************************
    // Vector types
    // **************************************************

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [5:0]        imem_idx_t;      // Word index into instr_mem
    typedef logic [3*XLEN-1:0] queue_entry_t;   // {instr, addr, addr + 4}
    typedef logic [3:0]        queue_ptr_t;
    typedef logic [4:0]        queue_count_t;   // 0 .. QUEUE_DEPTH
    typedef logic [6:0]        opcode_t;
    typedef logic [4:0]        reg_idx_t;

    // **************************************************
    // Addresses
    // **************************************************

    localparam word_t RESET_PC = '0;

    // Byte addresses wrap at the end of the instruction memory
    localparam word_t IMEM_ADDR_MASK = word_t'(IMEM_WORDS * 4 - 1);

endpackage

`default_nettype wire

// File: logic/instr_mem.sv
`timescale 1ns/10ps
`default_nettype none

module instr_mem
    import fetch_pkg::*;
(
    input  wire logic      CLK,

    // Load port
    input  wire logic      load_en,
    input  wire imem_idx_t load_addr,
    input  wire word_t     load_data,

    // Read port
    input  wire logic      rd_en,
    input  wire imem_idx_t rd_idx,
    output word_t          rd_data
);

    word_t mem [IMEM_WORDS];

    // **************************************************
    // Write side
    // **************************************************

    always_ff @(posedge CLK) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // **************************************************
    // Read side
    // **************************************************

    // Output register keeps its word until the next read
    always_ff @(posedge CLK) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
(
    input  wire logic  CLK,
    input  wire logic  RESET,

    input  wire logic  redirect_valid,
    input  wire word_t redirect_pc,

    // Instruction memory read
    output logic       rd_en,
    output imem_idx_t  rd_idx,
    input  wire word_t rd_data,

    // Queue push
    output logic         pushing,
    input  wire logic    push_must_wait,
    output queue_entry_t in_data
);

    logic         active;       // Leaves park one edge after reset
    word_t        pc;           // Next address to read
    logic         rd_valid;     // rd_data holds an unused word
    word_t        rd_addr;      // Address of the word on rd_data
    logic         held_valid;
    queue_entry_t held_entry;
    logic         push_stall;
    logic         load_held;

    function automatic word_t wrap_next(input word_t addr);
        word_t sum;
        sum = addr + word_t'(4);
        return sum & IMEM_ADDR_MASK;
    endfunction

    // **************************************************
    // Read issue and push strobe
    // **************************************************

    assign push_stall = held_valid && push_must_wait;
    assign load_held  = rd_valid && !push_stall;

    // No new read while the held entry is refused
    assign rd_en   = active && !redirect_valid && !push_stall;
    assign rd_idx  = imem_idx_t'(pc >> 2);

    assign pushing = held_valid;
    assign in_data = held_entry;

    // **************************************************
    // Control state
    // **************************************************

    always_ff @(posedge CLK) begin
        if (!RESET) begin
            active     <= 1'b0;
            pc         <= RESET_PC;
            rd_valid   <= 1'b0;
            held_valid <= 1'b0;
        end else begin
            active <= 1'b1;
            if (redirect_valid) begin
                pc         <= redirect_pc;     // Drop word in flight and held entry
                rd_valid   <= 1'b0;
                held_valid <= 1'b0;
            end else begin
                if (rd_en) begin
                    pc <= wrap_next(pc);
                end
                rd_valid   <= rd_en || (rd_valid && !load_held);
                held_valid <= load_held || push_stall;
            end
        end
    end

    // Payload
    always_ff @(posedge CLK) begin
        if (rd_en) begin
            rd_addr <= pc;
        end
        if (load_held) begin
            held_entry <= {rd_data, rd_addr, wrap_next(rd_addr)};
        end
    end

endmodule

`default_nettype wire

// File: logic/instr_queue.sv
`timescale 1ns/10ps
`default_nettype none

module instr_queue
    import fetch_pkg::*;
(
    input  wire logic         CLK,
    input  wire logic         RESET,
    input  wire logic         flush,

    input  wire logic         pushing,
    input  wire logic         popping,
    input  wire queue_entry_t in_data,

    output logic              push_must_wait,
    output logic              pop_must_wait,
    output queue_entry_t      out_data
);

    queue_entry_t slots [QUEUE_DEPTH];
    queue_ptr_t   head;             // Oldest entry
    queue_ptr_t   tail;             // Next free slot
    queue_count_t count;

    logic full;
    logic empty;
    logic do_push;
    logic do_pop;

    function automatic queue_ptr_t ptr_next(input queue_ptr_t ptr);
        if (ptr == queue_ptr_t'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // **************************************************
    // Status and replies
    // **************************************************

    assign full  = (count == queue_count_t'(QUEUE_DEPTH));
    assign empty = (count == '0);

    // A pop in the same cycle frees the slot, so no wait then
    assign push_must_wait = pushing && !popping && full;
    assign pop_must_wait  = popping && !pushing && empty;

    // Empty queue hands the pushed entry straight through
    assign out_data = empty ? in_data : slots[head];

    // **************************************************
    // Push and pop cases
    // **************************************************

    always_comb begin
        do_push = 1'b0;
        do_pop  = 1'b0;
        case ({pushing, popping})
            2'b10: begin
                do_push = !full;
            end
            2'b01: begin
                do_pop = !empty;
            end
            2'b11: begin
                do_push = !empty;       // Bypass when empty, nothing stored
                do_pop  = !empty;
            end
            default: begin
                do_push = 1'b0;
                do_pop  = 1'b0;
            end
        endcase
    end

    // **************************************************
    // Pointers and occupancy
    // **************************************************

    always_ff @(posedge CLK) begin
        if (!RESET || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                tail <= ptr_next(tail);
            end
            if (do_pop) begin
                head <= ptr_next(head);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge CLK) begin
        if (do_push) begin
            slots[tail] <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/decode_unit.sv
`timescale 1ns/10ps
`default_nettype none

module decode_unit
    import fetch_pkg::*;
(
    input  wire logic         CLK,
    input  wire logic         RESET,
    input  wire logic         flush,
    input  wire logic         issue_stall,

    // Queue pop
    output logic              popping,
    input  wire logic         pop_must_wait,
    input  wire queue_entry_t out_data,

    // Decoded fields
    output logic              dec_valid,
    output word_t             dec_pc,
    output word_t             dec_next_pc,
    output word_t             dec_instr,
    output opcode_t           dec_opcode,
    output reg_idx_t          dec_rd,
    output reg_idx_t          dec_rs1,
    output reg_idx_t          dec_rs2,
    output word_t             dec_imm
);

    logic  run;         // Pops start one edge after reset
    logic  take;
    word_t instr;

    assign popping = run && !issue_stall;
    assign take    = popping && !pop_must_wait;
    assign instr   = out_data[3*XLEN-1:2*XLEN];

    // **************************************************
    // Control
    // **************************************************

    always_ff @(posedge CLK) begin
        if (!RESET) begin
            run       <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            // One valid cycle per new result
            dec_valid <= take && !flush;
        end
    end

    // **************************************************
    // Field split
    // **************************************************

    // Held while issue stalls
    always_ff @(posedge CLK) begin
        if (take) begin
            dec_instr   <= instr;
            dec_pc      <= out_data[2*XLEN-1:XLEN];
            dec_next_pc <= out_data[XLEN-1:0];
            dec_opcode  <= instr[6:0];
            dec_rd      <= instr[11:7];
            dec_rs1     <= instr[19:15];
            dec_rs2     <= instr[24:20];
            dec_imm     <= {{20{instr[31]}}, instr[31:20]};    // I-type
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_decode_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_decode_top
    import fetch_pkg::*;
(
    input  wire logic      CLK,
    input  wire logic      RESET,

    input  wire logic      load_en,
    input  wire imem_idx_t load_addr,
    input  wire word_t     load_data,

    input  wire logic      redirect_valid,
    input  wire word_t     redirect_pc,
    input  wire logic      issue_stall,

    output wire logic      dec_valid,
    output wire word_t     dec_pc,
    output wire word_t     dec_next_pc,
    output wire word_t     dec_instr,
    output wire opcode_t   dec_opcode,
    output wire reg_idx_t  dec_rd,
    output wire reg_idx_t  dec_rs1,
    output wire reg_idx_t  dec_rs2,
    output wire word_t     dec_imm
);

    wire logic         rd_en;
    wire imem_idx_t    rd_idx;
    wire word_t        rd_data;
    wire logic         pushing;
    wire logic         push_must_wait;
    wire queue_entry_t in_data;
    wire logic         popping;
    wire logic         pop_must_wait;
    wire queue_entry_t out_data;

    instr_mem instr_mem_inst (
        .CLK       (CLK),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_en     (rd_en),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data)
    );

    fetch_unit fetch_unit_inst (
        .CLK            (CLK),
        .RESET          (RESET),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .rd_en          (rd_en),
        .rd_idx         (rd_idx),
        .rd_data        (rd_data),
        .pushing        (pushing),
        .push_must_wait (push_must_wait),
        .in_data        (in_data)
    );

    // Redirect doubles as queue flush
    instr_queue instr_queue_inst (
        .CLK            (CLK),
        .RESET          (RESET),
        .flush          (redirect_valid),
        .pushing        (pushing),
        .popping        (popping),
        .in_data        (in_data),
        .push_must_wait (push_must_wait),
        .pop_must_wait  (pop_must_wait),
        .out_data       (out_data)
    );

    decode_unit decode_unit_inst (
        .CLK           (CLK),
        .RESET         (RESET),
        .flush         (redirect_valid),
        .issue_stall   (issue_stall),
        .popping       (popping),
        .pop_must_wait (pop_must_wait),
        .out_data      (out_data),
        .dec_valid     (dec_valid),
        .dec_pc        (dec_pc),
        .dec_next_pc   (dec_next_pc),
        .dec_instr     (dec_instr),
        .dec_opcode    (dec_opcode),
        .dec_rd        (dec_rd),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_imm       (dec_imm)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    input  wire logic hold_reset,
    output logic      CLK,
    output logic      RESET
);

    int   cycles;
    logic hold_q;

    initial begin
        CLK    = 1'b0;
        RESET  = 1'b0;
        cycles = 0;
    end

    always #20 CLK = ~CLK;      // 40 ns period

    // RESET low for the first 16 edges and while hold_reset is up
    always @(posedge CLK) begin
        hold_q = hold_reset;
        if (cycles < 16) begin
            cycles = cycles + 1;
        end
        #2;
        RESET = (cycles >= 16) && !hold_q;
    end

endmodule

`default_nettype wire

// File: test/instr_queue_checker.sv
`timescale 1ns/10ps
`default_nettype none

module instr_queue_checker
    import fetch_pkg::*;
(
    input wire logic         CLK,
    input wire logic         RESET,
    input wire logic         flush,
    input wire logic         popping,
    input wire logic         push_must_wait,
    input wire logic         pop_must_wait,
    input wire queue_ptr_t   head,
    input wire queue_ptr_t   tail,
    input wire queue_count_t count,
    input wire queue_entry_t out_data
);

    int failures = 0;

    // **************************************************
    // Occupancy and must_wait rules
    // **************************************************

    occupancy_bound: assert property (@(posedge CLK) disable iff (!RESET)
        count <= queue_count_t'(QUEUE_DEPTH))
    else begin
        $error("queue occupancy above its depth");
        failures++;
    end

    // Full queue has its pointers meeting
    push_wait_full: assert property (@(posedge CLK) disable iff (!RESET)
        push_must_wait |-> (count == queue_count_t'(QUEUE_DEPTH)) && (head == tail))
    else begin
        $error("push_must_wait raised on a queue that is not full");
        failures++;
    end

    pop_wait_empty: assert property (@(posedge CLK) disable iff (!RESET)
        pop_must_wait |-> (count == '0) && (head == tail))
    else begin
        $error("pop_must_wait raised on a queue that is not empty");
        failures++;
    end

    // Head entry stays put until popped
    head_stable: assert property (@(posedge CLK) disable iff (!RESET)
        (!flush && count != '0 && !popping) |=> $stable(out_data))
    else begin
        $error("stored queue entry changed while held");
        failures++;
    end

endmodule

bind instr_queue instr_queue_checker instr_queue_checker_inst (
    .CLK            (CLK),
    .RESET          (RESET),
    .flush          (flush),
    .popping        (popping),
    .push_must_wait (push_must_wait),
    .pop_must_wait  (pop_must_wait),
    .head           (head),
    .tail           (tail),
    .count          (count),
    .out_data       (out_data)
);

`default_nettype wire

// File: test/fetch_decode_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_decode_tb
    import fetch_pkg::*;
();

    typedef struct packed {
        word_t    pc;
        word_t    next_pc;
        word_t    instr;
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
    } dec_fields_t;

    logic      CLK;
    logic      RESET;
    logic      hold_reset;
    logic      load_en;
    imem_idx_t load_addr;
    word_t     load_data;
    logic      redirect_valid;
    word_t     redirect_pc;
    logic      issue_stall;
    logic      dec_valid;
    word_t     dec_pc, dec_next_pc, dec_instr, dec_imm;
    opcode_t   dec_opcode;
    reg_idx_t  dec_rd, dec_rs1, dec_rs2;

    word_t       prog [IMEM_WORDS];    // Copy of the loaded program
    word_t       model_pc;             // Address of the next expected result
    logic        reset_seen;
    logic [31:0] lfsr_state;
    int          results;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;

    tb_clock_gen tb_clock_gen_inst (
        .hold_reset (hold_reset),
        .CLK        (CLK),
        .RESET      (RESET)
    );

    fetch_decode_top fetch_decode_top_inst (
        .CLK            (CLK),
        .RESET          (RESET),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .issue_stall    (issue_stall),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec_next_pc    (dec_next_pc),
        .dec_instr      (dec_instr),
        .dec_opcode     (dec_opcode),
        .dec_rd         (dec_rd),
        .dec_rs1        (dec_rs1),
        .dec_rs2        (dec_rs2),
        .dec_imm        (dec_imm)
    );

    // **************************************************
    // Random source and reference model
    // **************************************************

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hD000_0001;
        end
        return s >> 1;
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic word_t wrap_pc(input word_t addr);
        return (addr + 32'd4) % (IMEM_WORDS * 4);     // Byte wrap at end of memory
    endfunction

    function automatic dec_fields_t ref_decode(input word_t instr, input word_t addr);
        dec_fields_t f;
        f.pc      = addr;
        f.next_pc = wrap_pc(addr);
        f.instr   = instr;
        f.opcode  = instr[6:0];
        f.rd      = instr[11:7];
        f.rs1     = instr[19:15];
        f.rs2     = instr[24:20];
        f.imm     = word_t'($signed(instr[31:20]));
        return f;
    endfunction

    function automatic void check_field(input string name, input word_t got, input word_t want);
        assert (got == want) else begin
            $display("[FAIL] %s got %h expected %h at %0t", name, got, want, $time);
            errors++;
        end
    endfunction

    // **************************************************
    // Compare process
    // **************************************************

    always @(negedge CLK) begin
        dec_fields_t want;
        if (reset_seen) begin
            check_field("dec_valid", word_t'(dec_valid), '0);
        end else if (dec_valid === 1'b1) begin
            want = ref_decode(prog[model_pc[7:2]], model_pc);
            check_field("dec_pc", dec_pc, want.pc);
            check_field("dec_next_pc", dec_next_pc, want.next_pc);
            check_field("dec_instr", dec_instr, want.instr);
            check_field("dec_opcode", word_t'(dec_opcode), word_t'(want.opcode));
            check_field("dec_rd", word_t'(dec_rd), word_t'(want.rd));
            check_field("dec_rs1", word_t'(dec_rs1), word_t'(want.rs1));
            check_field("dec_rs2", word_t'(dec_rs2), word_t'(want.rs2));
            check_field("dec_imm", dec_imm, want.imm);
            model_pc = want.next_pc;
            results++;
        end
        // Next edge restarts the stream
        if (RESET !== 1'b1) begin
            model_pc = RESET_PC;
        end else if (redirect_valid) begin
            model_pc = redirect_pc;
        end
        reset_seen = (RESET !== 1'b1);
    end

    // **************************************************
    // Stimulus helpers
    // **************************************************

    task automatic next_cycle();
        @(posedge CLK);
        #2;
    endtask

    task automatic wait_results(input int n, input logic random_stall);
        int          target;
        int          idle;
        int          last;
        logic [31:0] bits;
        target = results + n;
        idle   = 0;
        last   = results;
        while (results < target && !timed_out) begin
            next_cycle();
            if (random_stall) begin
                random_bits(1, bits);
                issue_stall = bits[0];
            end
            idle = (results == last) ? idle + 1 : 0;
            last = results;
            if (idle >= 200) begin
                $display("Timeout: no decoded result for 200 cycles, %0d still missing",
                         target - results);
                timed_out = 1'b1;
            end
        end
        issue_stall = 1'b0;
    endtask

    // DUT sees RESET high two edges after release and dec_valid 3 cycles later
    task automatic release_and_time_first();
        int cycles;
        cycles     = 0;
        hold_reset = 1'b0;
        while (dec_valid !== 1'b1 && cycles < 200 && !timed_out) begin
            next_cycle();
            cycles++;
        end
        if (cycles >= 200) begin
            $display("Timeout: no dec_valid within 200 cycles of reset release");
            timed_out = 1'b1;
        end else begin
            assert (cycles == 5) else begin
                $display("[FAIL] first dec_valid cycle got %h expected %h", cycles, 5);
                errors++;
            end
        end
    endtask

    task automatic end_test(input int id, input string name);
        logic ok;
        ok = (errors == test_errors) && !timed_out;
        tests_run++;
        if (!ok) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", id, name, ok ? "pass" : "fail");
        test_errors = errors;
    endtask

    // **************************************************
    // Test sequence
    // **************************************************

    initial begin
        logic [31:0] bits;
        int          checker_failures;
        lfsr_state     = 32'd65894;
        hold_reset     = 1'b1;
        load_en        = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        issue_stall    = 1'b0;
        results        = 0;
        errors         = 0;
        test_errors    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        timed_out      = 1'b0;
        reset_seen     = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            random_bits(XLEN, bits);
            prog[i] = bits;
        end
        for (int i = 0; i < IMEM_WORDS; i++) begin     // Loaded while RESET is held
            next_cycle();
            load_en   = 1'b1;
            load_addr = imem_idx_t'(i);
            load_data = prog[i];
        end
        next_cycle();
        load_en = 1'b0;

        release_and_time_first();
        wait_results(20, 1'b0);
        end_test(1, "reset and first results");

        issue_stall = 1'b1;
        repeat (40) next_cycle();       // Long enough to fill the queue
        issue_stall = 1'b0;
        wait_results(40, 1'b0);
        end_test(2, "long issue stall");

        wait_results(300, 1'b1);
        end_test(3, "random issue stall with wraparound");

        issue_stall = 1'b1;
        repeat (8) next_cycle();
        random_bits(6, bits);
        redirect_valid = 1'b1;
        redirect_pc    = word_t'({bits[5:0], 2'b00});
        next_cycle();
        redirect_valid = 1'b0;
        issue_stall    = 1'b0;
        wait_results(30, 1'b0);
        end_test(4, "redirect flush");

        wait_results(10, 1'b1);
        hold_reset = 1'b1;
        repeat (6) next_cycle();
        release_and_time_first();
        wait_results(20, 1'b0);
        end_test(5, "reset in mid run");

        checker_failures = fetch_decode_top_inst.instr_queue_inst.instr_queue_checker_inst.failures;
        $display("tests %0d, failing %0d, results %0d, errors %0d, checker failures %0d",
                 tests_run, tests_failed, results, errors, checker_failures);
        if (errors == 0 && tests_failed == 0 && checker_failures == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
logic/fetch_pkg.sv
logic/instr_mem.sv
logic/fetch_unit.sv
logic/instr_queue.sv
logic/decode_unit.sv
logic/fetch_decode_top.sv
test/tb_clock_gen.sv
test/instr_queue_checker.sv
test/fetch_decode_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build fetch_decode_tb with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module fetch_decode_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vfetch_decode_tb); echo "$$out"; \
		echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
